/* hw/spk_out_pkg.sv */
`default_nettype none

package spk_out_pkg;

    // flit layout {type, route, payload}
    localparam int FLIT_W      = 59;
    localparam int TYPE_W      = 3;
    localparam int ROUTE_W     = 21;
    localparam int TYPE_MSB    = 58;
    localparam int ROUTE_MSB   = 55;
    localparam int ROUTE_LSB   = 35;
    localparam int NEURON_ID_W = 24;

    // route entry is {x, y, r2, r1, cont}, cont sits in bit 0
    localparam int CONT_BIT = 0;

    // destination table
    localparam int DST_ADDR_W = 4;
    localparam int DST_DEPTH  = 16;

    // output queue
    localparam int FIFO_ADDR_W = 4;
    localparam int FIFO_DEPTH  = 16;
    localparam int FIFO_AFULL  = 15;

    // router buffer credits
    localparam int CREDIT_W   = 4;
    localparam int CREDIT_MAX = 15;

    typedef logic [FLIT_W-1:0]      flit_t;
    typedef logic [TYPE_W-1:0]      flit_type_t;
    typedef logic [ROUTE_W-1:0]     route_t;
    typedef logic [NEURON_ID_W-1:0] neuron_id_t;
    typedef logic [DST_ADDR_W-1:0]  dst_addr_t;
    typedef logic [FIFO_ADDR_W-1:0] fifo_addr_t;
    typedef logic [CREDIT_W-1:0]    credit_t;

    // flit types
    localparam flit_type_t SPIKE    = 3'b000;
    localparam flit_type_t DATA     = 3'b001;
    localparam flit_type_t DATA_END = 3'b010;
    localparam flit_type_t WRITE    = 3'b110;
    localparam flit_type_t READ     = 3'b111;

    // sender FSM
    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT,
        S_SEND
    } send_state_t;

endpackage

`default_nettype wire

/* hw/dst_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module dst_ram (
    input  wire                   clk,
    input  wire                   wr_en,
    input  spk_out_pkg::dst_addr_t wr_addr,
    input  spk_out_pkg::route_t    wr_data,
    input  wire                   rd_en,
    input  spk_out_pkg::dst_addr_t rd_addr,
    output spk_out_pkg::route_t    rd_data
);

    import spk_out_pkg::*;

    route_t mem [DST_DEPTH];

    // table is loaded by the node controller before use
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, holds the last entry between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

/* hw/data_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module data_fifo (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 wr_en,
    input  wire                 rd_en,
    input  spk_out_pkg::flit_t  din,
    output spk_out_pkg::flit_t  dout,
    output logic                almost_full,
    output logic                empty
);

    import spk_out_pkg::*;

    flit_t                  mem [FIFO_DEPTH];
    fifo_addr_t             wr_ptr;
    fifo_addr_t             rd_ptr;
    logic [FIFO_ADDR_W:0]   count;
    logic                   full;
    logic                   do_wr;
    logic                   do_rd;

    assign full        = (count == FIFO_DEPTH);
    assign empty       = (count == '0);
    assign almost_full = (count >= FIFO_AFULL);

    // drop pushes when full, ignore pops when empty
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (do_rd) begin
            dout <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous push and pop keeps the count
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/spike_ingress.sv */
`timescale 1ns/1ns
`default_nettype none

module spike_ingress (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     soma_fire,
    input  spk_out_pkg::neuron_id_t neuron_id,
    input  wire                     config_we,
    input  spk_out_pkg::flit_t      config_flit,
    output logic                    config_full,
    input  wire                     pop,
    output spk_out_pkg::flit_t      pop_data,
    output logic                    empty
);

    import spk_out_pkg::*;

    logic  push;
    flit_t push_data;
    flit_t spike_flit;

    // spike flit carries no route yet, the sender fills it in
    always_comb begin
        spike_flit                        = '0;
        spike_flit[TYPE_MSB:ROUTE_MSB+1]  = SPIKE;
        spike_flit[NEURON_ID_W-1:0]       = neuron_id;
    end

    // spike wins over a config write in the same cycle
    assign push      = soma_fire || config_we;
    assign push_data = soma_fire ? spike_flit : config_flit;

    data_fifo i_data_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_en       (push),
        .rd_en       (pop),
        .din         (push_data),
        .dout        (pop_data),
        .almost_full (config_full),
        .empty       (empty)
    );

endmodule

`default_nettype wire

/* hw/flit_sender.sv */
`timescale 1ns/1ns
`default_nettype none

module flit_sender (
    input  wire                     clk,
    input  wire                     rst_n,
    output logic                    pop,
    input  spk_out_pkg::flit_t      pop_data,
    input  wire                     empty,
    input  wire                     credit_in,
    output logic                    flit_out_wr,
    output spk_out_pkg::flit_t      flit_out,
    input  wire                     dst_we,
    input  spk_out_pkg::dst_addr_t  dst_waddr,
    input  spk_out_pkg::route_t     dst_wdata,
    input  wire                     dst_re,
    input  spk_out_pkg::dst_addr_t  dst_raddr,
    output spk_out_pkg::route_t     dst_rdata
);

    import spk_out_pkg::*;

    send_state_t state;
    send_state_t state_nxt;
    credit_t     credit;
    dst_addr_t   dst_addr;
    dst_addr_t   tbl_raddr;
    logic        tbl_re;
    logic        more_dst;
    logic        can_send;
    flit_type_t  out_type;
    flit_type_t  in_type;

    assign out_type = flit_out[TYPE_MSB:ROUTE_MSB+1];
    assign in_type  = pop_data[TYPE_MSB:ROUTE_MSB+1];

    // the route in flit_out still holds the continue flag of the entry
    // READ flits are never multicast
    assign more_dst = (out_type != READ) && flit_out[ROUTE_LSB+CONT_BIT];
    assign can_send = (credit != '0);

    assign flit_out_wr = (state == S_SEND);

    always_comb begin
        state_nxt = state;
        pop       = 1'b0;
        tbl_re    = 1'b0;
        tbl_raddr = '0;
        case (state)
            S_IDLE: begin
                if (!empty) begin
                    pop       = 1'b1;
                    tbl_re    = 1'b1;
                    state_nxt = S_WAIT;
                end
            end
            S_WAIT: begin
                if (can_send) begin
                    state_nxt = S_SEND;
                end
            end
            S_SEND: begin
                if (more_dst) begin
                    // next copy of the same flit
                    tbl_re    = 1'b1;
                    tbl_raddr = dst_addr + 1'b1;
                    state_nxt = S_WAIT;
                end else if (!empty) begin
                    pop       = 1'b1;
                    tbl_re    = 1'b1;
                    state_nxt = S_WAIT;
                end else begin
                    state_nxt = S_IDLE;
                end
            end
            default: begin
                state_nxt = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            dst_addr <= '0;
        end else begin
            state <= state_nxt;
            // walk forward on multicast, back to entry 0 otherwise
            if (tbl_re || flit_out_wr) begin
                dst_addr <= tbl_raddr;
            end
        end
    end

    // merge type, table route and payload
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flit_out <= '0;
        end else if ((state == S_WAIT) && can_send) begin
            if (in_type == READ) begin
                flit_out <= pop_data;
            end else begin
                flit_out <= {in_type, dst_rdata, pop_data[ROUTE_LSB-1:0]};
            end
        end
    end

    // one credit per flit sent, one back per freed router slot
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit <= credit_t'(CREDIT_MAX);
        end else begin
            case ({credit_in, flit_out_wr})
                2'b10:   credit <= credit + 1'b1;
                2'b01:   credit <= credit - 1'b1;
                default: credit <= credit;
            endcase
        end
    end

    // sender reads take the shared port first
    dst_ram i_dst_ram (
        .clk     (clk),
        .wr_en   (dst_we),
        .wr_addr (dst_waddr),
        .wr_data (dst_wdata),
        .rd_en   (tbl_re || dst_re),
        .rd_addr (tbl_re ? tbl_raddr : dst_raddr),
        .rd_data (dst_rdata)
    );

endmodule

`default_nettype wire

/* hw/spk_out.sv */
`timescale 1ns/1ns
`default_nettype none

module spk_out (
    input  wire                     clk,
    input  wire                     rst_n,
    // soma and node controller
    input  wire                     soma_fire,
    input  spk_out_pkg::neuron_id_t neuron_id,
    input  wire                     config_we,
    input  spk_out_pkg::flit_t      config_flit,
    output logic                    config_full,
    // router
    input  wire                     credit_in,
    output logic                    flit_out_wr,
    output spk_out_pkg::flit_t      flit_out,
    // destination table access
    input  wire                     dst_we,
    input  spk_out_pkg::dst_addr_t  dst_waddr,
    input  spk_out_pkg::route_t     dst_wdata,
    input  wire                     dst_re,
    input  spk_out_pkg::dst_addr_t  dst_raddr,
    output spk_out_pkg::route_t     dst_rdata
);

    import spk_out_pkg::*;

    logic  pop;
    flit_t pop_data;
    logic  empty;

    spike_ingress i_spike_ingress (
        .clk         (clk),
        .rst_n       (rst_n),
        .soma_fire   (soma_fire),
        .neuron_id   (neuron_id),
        .config_we   (config_we),
        .config_flit (config_flit),
        .config_full (config_full),
        .pop         (pop),
        .pop_data    (pop_data),
        .empty       (empty)
    );

    flit_sender i_flit_sender (
        .clk         (clk),
        .rst_n       (rst_n),
        .pop         (pop),
        .pop_data    (pop_data),
        .empty       (empty),
        .credit_in   (credit_in),
        .flit_out_wr (flit_out_wr),
        .flit_out    (flit_out),
        .dst_we      (dst_we),
        .dst_waddr   (dst_waddr),
        .dst_wdata   (dst_wdata),
        .dst_re      (dst_re),
        .dst_raddr   (dst_raddr),
        .dst_rdata   (dst_rdata)
    );

endmodule

`default_nettype wire

/* verification/tb_spk_out.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_spk_out;

    import spk_out_pkg::*;

    logic       clk;
    logic       rst_n;
    logic       soma_fire;
    neuron_id_t neuron_id;
    logic       config_we;
    flit_t      config_flit;
    logic       config_full;
    logic       credit_in = 1'b0;
    logic       flit_out_wr;
    flit_t      flit_out;
    logic       dst_we;
    dst_addr_t  dst_waddr;
    route_t     dst_wdata;
    logic       dst_re;
    dst_addr_t  dst_raddr;
    route_t     dst_rdata;

    integer seed = 32'he97091ed;
    int     errors = 0;
    int     tests = 0;
    int     failed = 0;
    int     test_base = 0;
    int     cyc = 0;
    int     owed = 0;
    int     fire_cyc = 0;
    logic   credit_en = 1'b1;
    flit_t  rx_q[$];
    int     rx_cyc[$];
    flit_t  exp_q[$];
    route_t tbl[DST_DEPTH];

    spk_out i_spk_out (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // router model returns one credit per cycle while any are owed
    always @(negedge clk) begin
        if (credit_en && owed > 0) begin
            credit_in = 1'b1;
            owed = owed - 1;
        end else begin
            credit_in = 1'b0;
        end
        if (flit_out_wr) begin
            rx_q.push_back(flit_out);
            rx_cyc.push_back(cyc);
            owed = owed + 1;
        end
    end

    function automatic route_t random_route(input logic cont);
        logic [31:0] r;
        r = $random(seed);
        return {r[ROUTE_W-1:1], cont};
    endfunction

    function automatic neuron_id_t new_neuron_id();
        logic [31:0] r;
        r = $random(seed);
        return r[NEURON_ID_W-1:0];
    endfunction

    function automatic flit_t make_config_flit(input flit_type_t t);
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        r1 = $random(seed);
        r2 = $random(seed);
        r3 = $random(seed);
        return {t, r1[ROUTE_W-1:0], r2[2:0], r3};
    endfunction

    // spike payload is the neuron id with zero upper bits
    function automatic flit_t expect_spike(input route_t r, input neuron_id_t nid);
        return {SPIKE, r, 11'b0, nid};
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] got);
        errors++;
        $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, got);
    endtask

    task automatic open_test();
        test_base = errors;
        rx_q.delete();
        rx_cyc.delete();
        exp_q.delete();
    endtask

    task automatic close_test(input string name);
        tests++;
        if (errors == test_base) begin
            $display("%s: ok", name);
        end else begin
            failed++;
            $display("%s: failed with %0d errors", name, errors - test_base);
        end
    endtask

    task automatic write_route(input dst_addr_t a, input route_t r);
        @(negedge clk);
        dst_we = 1'b1;
        dst_waddr = a;
        dst_wdata = r;
        tbl[a] = r;
        @(negedge clk);
        dst_we = 1'b0;
    endtask

    task automatic fire_spike(input neuron_id_t nid);
        @(negedge clk);
        soma_fire = 1'b1;
        neuron_id = nid;
        fire_cyc = cyc;
        @(negedge clk);
        soma_fire = 1'b0;
    endtask

    task automatic send_config(input flit_t f);
        @(negedge clk);
        config_we = 1'b1;
        config_flit = f;
        @(negedge clk);
        config_we = 1'b0;
    endtask

    task automatic wait_flits(input int n, input int limit);
        int i;
        for (i = 0; i < limit; i++) begin
            @(posedge clk);
            if (rx_q.size() >= n) break;
        end
        if (rx_q.size() < n) begin
            errors++;
            $display("timeout after %0d cycles, %0d of %0d flits seen", limit, rx_q.size(), n);
        end
    endtask

    // wait for all credits to come home and then a few quiet cycles for stray flits
    task automatic settle();
        int i;
        for (i = 0; i < 100; i++) begin
            @(posedge clk);
            if (owed == 0) break;
        end
        if (owed != 0) begin
            errors++;
            $display("timeout waiting for %0d credits to return", owed);
        end
        repeat (8) @(posedge clk);
    endtask

    task automatic compare_rx();
        if (rx_q.size() != exp_q.size()) begin
            errors++;
            $display("got %0d flits, expected %0d", rx_q.size(), exp_q.size());
        end
        foreach (exp_q[i]) begin
            if (i < rx_q.size() && rx_q[i] !== exp_q[i]) begin
                report_mismatch("flit_out", 64'(exp_q[i]), 64'(rx_q[i]));
            end
        end
    endtask

    task automatic check_reset_state();
        open_test();
        @(negedge clk);
        if (flit_out_wr !== 1'b0) report_mismatch("flit_out_wr", 64'(0), 64'(flit_out_wr));
        if (config_full !== 1'b0) report_mismatch("config_full", 64'(0), 64'(config_full));
        if (flit_out !== '0) report_mismatch("flit_out", 64'(0), 64'(flit_out));
        close_test("reset state");
    endtask

    task automatic table_readback();
        int i;
        open_test();
        for (i = 0; i < DST_DEPTH; i++) begin
            write_route(dst_addr_t'(i), random_route(i[0]));
        end
        for (i = 0; i < DST_DEPTH; i++) begin
            @(negedge clk);
            dst_re = 1'b1;
            dst_raddr = dst_addr_t'(i);
            @(negedge clk);
            dst_re = 1'b0;
            if (dst_rdata !== tbl[i]) report_mismatch("dst_rdata", 64'(tbl[i]), 64'(dst_rdata));
        end
        close_test("destination table");
    endtask

    task automatic unicast_spike();
        neuron_id_t nid;
        open_test();
        write_route(0, random_route(1'b0));
        nid = new_neuron_id();
        exp_q.push_back(expect_spike(tbl[0], nid));
        fire_spike(nid);
        wait_flits(1, 20);
        settle();
        compare_rx();
        if (rx_cyc.size() > 0 && rx_cyc[0] - fire_cyc != 3) begin
            errors++;
            $display("flit came %0d cycles after soma_fire, expected 3", rx_cyc[0] - fire_cyc);
        end
        close_test("unicast spike");
    endtask

    task automatic multicast_spikes();
        neuron_id_t nid_a;
        neuron_id_t nid_b;
        int         first_cyc;
        int         i;
        open_test();
        write_route(0, random_route(1'b1));
        write_route(1, random_route(1'b1));
        write_route(2, random_route(1'b0));
        nid_a = new_neuron_id();
        nid_b = new_neuron_id();
        for (i = 0; i < 3; i++) begin
            exp_q.push_back(expect_spike(tbl[i], nid_a));
        end
        for (i = 0; i < 3; i++) begin
            exp_q.push_back(expect_spike(tbl[i], nid_b));
        end
        fire_spike(nid_a);
        first_cyc = fire_cyc;
        fire_spike(nid_b);
        wait_flits(6, 60);
        settle();
        compare_rx();
        if (rx_cyc.size() > 0 && rx_cyc[0] - first_cyc != 3) begin
            errors++;
            $display("first copy came %0d cycles after soma_fire, expected 3",
                     rx_cyc[0] - first_cyc);
        end
        for (i = 1; i < rx_cyc.size(); i++) begin
            if (rx_cyc[i] - rx_cyc[i-1] != 2) begin
                errors++;
                $display("flit %0d came %0d cycles after the one before, expected 2",
                         i, rx_cyc[i] - rx_cyc[i-1]);
            end
        end
        close_test("multicast spikes");
    endtask

    task automatic config_flits();
        flit_t wr;
        flit_t rd;
        open_test();
        write_route(0, random_route(1'b1));
        write_route(1, random_route(1'b0));
        wr = make_config_flit(WRITE);
        rd = make_config_flit(READ);
        // a set continue bit in the read's own route must not start a walk either
        rd[ROUTE_LSB+CONT_BIT] = 1'b1;
        // write goes to entries 0 and 1 while read passes once untouched
        exp_q.push_back({WRITE, tbl[0], wr[ROUTE_LSB-1:0]});
        exp_q.push_back({WRITE, tbl[1], wr[ROUTE_LSB-1:0]});
        exp_q.push_back(rd);
        send_config(wr);
        send_config(rd);
        wait_flits(3, 40);
        settle();
        compare_rx();
        close_test("config flits");
    endtask

    task automatic back_pressure();
        neuron_id_t nid;
        int         held;
        int         accepted;
        int         fill;
        logic       exp_full;
        int         i;
        open_test();
        write_route(0, random_route(1'b0));
        // one flit waits in the sender once credits run out and the FIFO takes the next 16
        held = CREDIT_MAX + 1;
        accepted = held + FIFO_DEPTH;
        credit_en = 1'b0;
        for (i = 1; i <= accepted + 4; i++) begin
            nid = new_neuron_id();
            if (i <= accepted) exp_q.push_back(expect_spike(tbl[0], nid));
            fire_spike(nid);
            fill = (i <= held) ? 1 : ((i - held > FIFO_DEPTH) ? FIFO_DEPTH : i - held);
            exp_full = (fill >= FIFO_AFULL);
            if (config_full !== exp_full) begin
                report_mismatch("config_full", 64'(exp_full), 64'(config_full));
            end
            repeat (3) @(negedge clk);
        end
        if (rx_q.size() != CREDIT_MAX) begin
            errors++;
            $display("%0d flits sent without credit return, expected %0d",
                     rx_q.size(), CREDIT_MAX);
        end
        @(posedge clk);
        credit_en = 1'b1;
        wait_flits(accepted, 400);
        settle();
        compare_rx();
        close_test("back-pressure");
    endtask

    initial begin
        rst_n = 1'b0;
        soma_fire = 1'b0;
        neuron_id = '0;
        config_we = 1'b0;
        config_flit = '0;
        dst_we = 1'b0;
        dst_waddr = '0;
        dst_wdata = '0;
        dst_re = 1'b0;
        dst_raddr = '0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        check_reset_state();
        table_readback();
        unicast_spike();
        multicast_spikes();
        config_flits();
        back_pressure();
        $display("tests run %0d, tests failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
hw/spk_out_pkg.sv
hw/dst_ram.sv
hw/data_fifo.sv
hw/spike_ingress.sv
hw/flit_sender.sv
hw/spk_out.sv
verification/tb_spk_out.sv

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_spk_out -f project.f
./obj_dir/Vtb_spk_out | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    echo "run_sim: simulation passed"
else
    echo "run_sim: simulation failed"
    exit 1
fi
